/* hw/branch_history_table.sv */
// Branch history table of 2-bit saturating counters
// Read combinationally at the fetch PC, trained by execute through bht_write
// A same-cycle write and read of one entry returns the old counter
`timescale 1ns/1ps

module branch_history_table
  import fetch_pkg::*;
(
  input  logic                clk,
  input  logic                rst,     // Sync, active high
  input  logic [PC_WIDTH-1:0] pc,      // Fetch PC
  input  branch_update_t      update,  // Resolved branch from execute
  output pred_count_t         count    // Counter at the fetch PC
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  pred_count_t count_mem [PRED_ENTRIES];  // One counter per index

  logic [PRED_INDEX_BITS-1:0] rd_idx;    // Fetch side
  logic [PRED_INDEX_BITS-1:0] wr_idx;    // Execute side
  pred_count_t                wr_value;  // Trained counter

  // Move one step toward the outcome, clamp at 0 and 3
  function automatic pred_count_t sat_step(pred_count_t value, logic taken);
    pred_count_t result;
    result = value;
    if (taken && (value != 2'd3)) begin
      result = value + 2'd1;
    end else if (!taken && (value != 2'd0)) begin
      result = value - 2'd1;
    end
    return result;
  endfunction

  assign rd_idx = pred_index(pc);
  assign wr_idx = pred_index(update.pc);

  // Train from the value seen at fetch time, not the current entry
  assign wr_value = sat_step(update.prediction, update.taken);

  ////////////////////////////////////////
  // Counter update
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      // All entries start weakly not taken
      for (int i = 0; i < int'(PRED_ENTRIES); i++) begin
        count_mem[i] <= BHT_RESET_VALUE;
      end
    end else if (update.bht_write) begin
      count_mem[wr_idx] <= wr_value;  // Visible next cycle
    end
  end

  // Asynchronous read, same cycle as the PC
  assign count = count_mem[rd_idx];

endmodule

/* hw/branch_target_buffer.sv */
// Direct-mapped, tagged branch target buffer
// Looked up combinationally at the fetch PC and filled by execute on btb_write
// Only the valid bits are cleared by reset
`timescale 1ns/1ps

module branch_target_buffer
  import fetch_pkg::*;
(
  input  logic                clk,
  input  logic                rst,     // Sync, active high
  input  logic [PC_WIDTH-1:0] pc,      // Fetch PC
  input  branch_update_t      update,  // Resolved branch from execute
  output logic                hit,     // Valid entry with matching tag
  output logic [PC_WIDTH-1:0] target   // Stored target at the fetch index
);

  ////////////////////////////////////////
  // Entry arrays
  ////////////////////////////////////////
  logic [PRED_ENTRIES-1:0] valid_mem;                // One valid bit per entry
  logic [BTB_TAG_BITS-1:0] tag_mem    [PRED_ENTRIES];
  logic [PC_WIDTH-1:0]     target_mem [PRED_ENTRIES];

  logic [PRED_INDEX_BITS-1:0] rd_idx;
  logic [PRED_INDEX_BITS-1:0] wr_idx;
  logic [BTB_TAG_BITS-1:0]    rd_tag;  // Tag of the fetch PC
  logic [BTB_TAG_BITS-1:0]    wr_tag;  // Tag of the resolved branch

  assign rd_idx = pred_index(pc);
  assign rd_tag = btb_tag(pc);
  assign wr_idx = pred_index(update.pc);
  assign wr_tag = btb_tag(update.pc);

  ////////////////////////////////////////
  // Writes from execute
  ////////////////////////////////////////
  // Valid bits, set by each write to the entry
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_mem <= '0;
    end else if (update.btb_write) begin
      valid_mem[wr_idx] <= 1'b1;
    end
  end

  // Tag and target payload
  always_ff @(posedge clk) begin
    if (update.btb_write) begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= update.target;  // Overwrites any older branch at this index
    end
  end

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////
  // Old contents win on a same-cycle write to this entry
  assign hit    = valid_mem[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign target = target_mem[rd_idx];  // Qualified by hit downstream

endmodule

/* hw/fetch_pkg.sv */
// Shared sizes, reset values and bundles for the instruction fetch stage
// Every fetch module and the testbench model import this package
// Index and tag helpers split a PC for lookup in both tables

package fetch_pkg;

  ////////////////////////////////////////
  // Sizes and reset values
  ////////////////////////////////////////
  localparam int unsigned PC_WIDTH        = 16;  // Byte address width
  localparam int unsigned PRED_ENTRIES    = 16;  // Entries in both BHT and BTB
  localparam int unsigned PRED_INDEX_BITS = 4;   // Table index from pc[4:1]
  localparam int unsigned BTB_TAG_BITS    = 11;  // BTB tag from pc[15:5]

  typedef logic [1:0] pred_count_t;  // 2-bit saturating counter value

  localparam pred_count_t BHT_RESET_VALUE = 2'd1;  // Weakly not taken
  localparam logic [PC_WIDTH-1:0] INSTR_STEP = PC_WIDTH'(2);  // 2-byte instructions

  // Halt tracking, held until execute redirects
  typedef enum logic {
    FETCH_RUN    = 1'b0,
    FETCH_HALTED = 1'b1
  } fetch_state_t;

  ////////////////////////////////////////
  // Bundles between stages
  ////////////////////////////////////////
  typedef struct packed {
    logic                bht_write;   // Train the counter
    logic                btb_write;   // Store the target
    logic [PC_WIDTH-1:0] pc;          // PC of the resolved branch
    pred_count_t         prediction;  // Counter value carried down the pipe
    logic                taken;       // Actual outcome
    logic [PC_WIDTH-1:0] target;      // Actual branch target
  } branch_update_t;

  typedef struct packed {
    logic                valid;
    logic [PC_WIDTH-1:0] target;  // Corrected fetch address
  } redirect_t;

  typedef struct packed {
    logic [PC_WIDTH-1:0] pc;                // Current fetch PC
    logic [PC_WIDTH-1:0] pc_next;           // Sequential successor
    pred_count_t         prediction;        // BHT counter at pc
    logic [PC_WIDTH-1:0] predicted_target;  // BTB target at pc
    logic                predicted_taken;   // Counter says taken and BTB hits
  } fetch_out_t;

  // Word-aligned index into both tables
  function automatic logic [PRED_INDEX_BITS-1:0] pred_index(logic [PC_WIDTH-1:0] pc);
    return pc[PRED_INDEX_BITS:1];
  endfunction

  // Upper PC bits left over after the index
  function automatic logic [BTB_TAG_BITS-1:0] btb_tag(logic [PC_WIDTH-1:0] pc);
    return pc[PC_WIDTH-1:PC_WIDTH-BTB_TAG_BITS];
  endfunction

endpackage

/* hw/fetch_sequencer.sv */
// PC register, halt state machine and next-PC selection for fetch
// Priority is stall, redirect, halt, predicted target, then PC plus 2
// The predictor tables feed count, btb_hit and btb_target back in the same cycle
`timescale 1ns/1ps

module fetch_sequencer
  import fetch_pkg::*;
(
  input  logic                clk,
  input  logic                rst,          // Sync, active high
  input  logic                stall,        // Hazard unit holds fetch
  input  logic                hlt_fetched,  // Decode saw a halt
  input  redirect_t           redirect,     // Misprediction fix from execute
  input  pred_count_t         count,        // BHT counter at pc
  input  logic                btb_hit,
  input  logic [PC_WIDTH-1:0] btb_target,
  output fetch_out_t          fetch,
  output logic                halted        // High in FETCH_HALTED
);

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////
  fetch_state_t        state_q;
  fetch_state_t        state_d;
  logic [PC_WIDTH-1:0] pc_q;             // Current fetch address
  logic [PC_WIDTH-1:0] pc_d;
  logic [PC_WIDTH-1:0] pc_next;          // Sequential successor
  logic                predicted_taken;

  assign pc_next = pc_q + INSTR_STEP;

  // Upper counter bit gives the direction, BTB must supply a target
  assign predicted_taken = count[1] & btb_hit;

  ////////////////////////////////////////
  // Next PC and next state
  ////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    if (redirect.valid) begin
      // Execute overrides halt and prediction
      pc_d    = redirect.target;
      state_d = FETCH_RUN;
    end else if ((state_q == FETCH_HALTED) || hlt_fetched) begin
      state_d = FETCH_HALTED;  // Park on the halt
    end else if (predicted_taken) begin
      pc_d = btb_target;
    end else begin
      pc_d = pc_next;
    end
  end

  // Stall freezes both PC and halt state
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= '0;
      state_q <= FETCH_RUN;
    end else if (!stall) begin
      pc_q    <= pc_d;
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////
  always_comb begin
    fetch.pc               = pc_q;
    fetch.pc_next          = pc_next;
    fetch.prediction       = count;       // Carried with the instruction for training
    fetch.predicted_target = btb_target;
    fetch.predicted_taken  = predicted_taken;
  end

  assign halted = (state_q == FETCH_HALTED);

endmodule

/* hw/fetch_stage.sv */
// Top of the instruction fetch stage
// Joins the PC sequencer with the branch history table and target buffer
// Execute feeds update and redirect, decode feeds hlt_fetched
`timescale 1ns/1ps

module fetch_stage
  import fetch_pkg::*;
(
  input  logic           clk,
  input  logic           rst,          // Sync, active high
  input  logic           stall,        // Only back-pressure into fetch
  input  logic           hlt_fetched,  // Halt decoded
  input  redirect_t      redirect,     // PC correction from execute
  input  branch_update_t update,       // Resolved branch for table training
  output fetch_out_t     fetch,        // PC and prediction to decode
  output logic           halted
);

  ////////////////////////////////////////
  // Predictor results at the fetch PC
  ////////////////////////////////////////
  pred_count_t         bht_count;
  logic                btb_hit;
  logic [PC_WIDTH-1:0] btb_target;

  fetch_sequencer i_fetch_sequencer (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .hlt_fetched (hlt_fetched),
    .redirect    (redirect),
    .count       (bht_count),
    .btb_hit     (btb_hit),
    .btb_target  (btb_target),
    .fetch       (fetch),
    .halted      (halted)
  );

  // Tables keep training while fetch is stalled
  branch_history_table i_branch_history_table (
    .clk    (clk),
    .rst    (rst),
    .pc     (fetch.pc),
    .update (update),
    .count  (bht_count)
  );

  branch_target_buffer i_branch_target_buffer (
    .clk    (clk),
    .rst    (rst),
    .pc     (fetch.pc),
    .update (update),
    .hit    (btb_hit),
    .target (btb_target)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator and run it.
# Exit status is non-zero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fetch_stage_sim

verilator --binary --timing --assert \
  -f sim.f \
  --top-module fetch_stage_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

/* sim.f */
hw/fetch_pkg.sv
hw/branch_history_table.sv
hw/branch_target_buffer.sv
hw/fetch_sequencer.sv
hw/fetch_stage.sv
test/fetch_stage_props.sv
test/fetch_stage_tb.sv

/* test/fetch_stage_props.sv */
// Concurrent checks on the fetch PC and halt behaviour
// Bound into every fetch_sequencer instance, watches the PC register directly
`timescale 1ns/1ps

module fetch_stage_props
  import fetch_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                stall,
  input logic                redirect_valid,
  input logic                halted,
  input logic [PC_WIDTH-1:0] pc              // Registered fetch PC
);

  ////////////////////////////////////////
  // PC rules
  ////////////////////////////////////////
  // 2-byte instructions keep bit 0 clear
  pc_even: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
    else $error("fetch PC is odd");

  pc_zero_after_reset: assert property (@(posedge clk) rst |=> (pc == '0))
    else $error("fetch PC not zero after reset");

  // Back-pressure freezes fetch
  pc_holds_on_stall: assert property (@(posedge clk) (stall && !rst) |=> $stable(pc))
    else $error("fetch PC moved under stall");

  // Only a redirect leaves the halted state
  pc_holds_when_halted: assert property (
    @(posedge clk) (halted && !redirect_valid && !rst) |=> $stable(pc)
  ) else $error("fetch PC moved while halted");

endmodule

bind fetch_sequencer fetch_stage_props i_fetch_stage_props (
  .clk            (clk),
  .rst            (rst),
  .stall          (stall),
  .redirect_valid (redirect.valid),
  .halted         (halted),
  .pc             (pc_q)
);

/* test/fetch_stage_tb.sv */
// Random-stimulus testbench for the instruction fetch stage
// A cycle model of PC, halt state, BHT and BTB predicts every output
// Outputs are compared one nanosecond before each rising edge
`timescale 1ns/1ps

module fetch_stage_tb
  import fetch_pkg::*;
();

  ////////////////////////////////////////
  // Run length and clocking
  ////////////////////////////////////////
  localparam int HALF_PERIOD    = 4;     // 8 ns clock
  localparam int RESET_CYCLES   = 5;
  localparam int SEQ_CYCLES     = 16;    // Idle walk over every table index
  localparam int RANDOM_CYCLES  = 2000;
  localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + RANDOM_CYCLES / 10;  // 10% margin
  localparam int SEED           = 4;

  logic           clk = 1'b0;
  logic           rst;
  logic           stall;
  logic           hlt_fetched;
  redirect_t      redirect;
  branch_update_t update;
  fetch_out_t     fetch;
  logic           halted;

  // Model state, updated once per rising edge
  pred_count_t             model_count  [PRED_ENTRIES];
  logic                    model_valid  [PRED_ENTRIES];
  logic [BTB_TAG_BITS-1:0] model_tag    [PRED_ENTRIES];
  logic [PC_WIDTH-1:0]     model_target [PRED_ENTRIES];
  logic [PC_WIDTH-1:0]     model_pc;
  logic                    model_halted;
  int                      cycle_count = 0;

  fetch_stage i_fetch_stage (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .hlt_fetched (hlt_fetched),
    .redirect    (redirect),
    .update      (update),
    .fetch       (fetch),
    .halted      (halted)
  );

  always #HALF_PERIOD clk = ~clk;

  // Hard stop if the main loop ever stalls
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////
  task automatic compare(string what, logic [15:0] actual, logic [15:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is 0x%h, expected 0x%h", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // One step toward the outcome, held at 0 and 3
  function automatic pred_count_t train_counter(pred_count_t seen, logic taken);
    if (taken) begin
      return (seen == 2'd3) ? 2'd3 : seen + 2'd1;
    end
    return (seen == 2'd0) ? 2'd0 : seen - 2'd1;
  endfunction

  function automatic bit percent_chance(int unsigned pct);
    return $urandom_range(0, 99) < pct;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < int'(PRED_ENTRIES); i++) begin
      model_count[i]  = BHT_RESET_VALUE;  // Weakly not taken
      model_valid[i]  = 1'b0;
      model_tag[i]    = '0;
      model_target[i] = '0;
    end
    model_pc     = '0;
    model_halted = 1'b0;
  endtask

  // Expected outputs from the model before the coming edge
  task automatic check_outputs();
    logic [PRED_INDEX_BITS-1:0] idx;
    pred_count_t                exp_count;
    logic                       exp_hit;
    logic                       exp_taken;
    idx       = model_pc[4:1];
    exp_count = model_count[idx];
    exp_hit   = model_valid[idx] && (model_tag[idx] == model_pc[15:5]);
    exp_taken = exp_count[1] && exp_hit;  // Direction and target both needed
    compare("pc", fetch.pc, model_pc);
    compare("pc_next", fetch.pc_next, model_pc + INSTR_STEP);
    compare("prediction", 16'(fetch.prediction), 16'(exp_count));
    compare("predicted_taken", 16'(fetch.predicted_taken), 16'(exp_taken));
    compare("halted", 16'(halted), 16'(model_halted));
    if (model_valid[idx]) begin
      compare("predicted_target", fetch.predicted_target, model_target[idx]);  // Known payload
    end
  endtask

  // Apply the next-PC priority and the table writes of this edge
  task automatic advance_model();
    logic [PRED_INDEX_BITS-1:0] idx;
    logic [PRED_INDEX_BITS-1:0] upd_idx;
    logic                       take_branch;
    idx         = model_pc[4:1];
    upd_idx     = update.pc[4:1];
    take_branch = model_count[idx][1] && model_valid[idx]
                  && (model_tag[idx] == model_pc[15:5]);
    if (!stall) begin
      if (redirect.valid) begin
        model_pc     = redirect.target;  // Beats halt and prediction
        model_halted = 1'b0;
      end else if (model_halted || hlt_fetched) begin
        model_halted = 1'b1;             // PC frozen
      end else if (take_branch) begin
        model_pc = model_target[idx];
      end else begin
        model_pc = model_pc + INSTR_STEP;
      end
    end
    // Tables train even under stall
    if (update.bht_write) begin
      model_count[upd_idx] = train_counter(update.prediction, update.taken);
    end
    if (update.btb_write) begin
      model_valid[upd_idx]  = 1'b1;
      model_tag[upd_idx]    = update.pc[15:5];
      model_target[upd_idx] = update.target;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic drive_idle();
    stall       = 1'b0;
    hlt_fetched = 1'b0;
    redirect    = '0;
    update      = '0;
  endtask

  task automatic drive_random();
    logic [31:0] rnd;
    rnd                = $urandom;
    stall              = percent_chance(20);
    hlt_fetched        = percent_chance(5);
    redirect.valid     = percent_chance(8);
    redirect.target    = {10'b0, rnd[4:0], 1'b0};   // Even, low 64 bytes
    update.pc          = {10'b0, rnd[9:5], 1'b0};   // Same range to reuse entries
    update.bht_write   = rnd[10];
    update.btb_write   = rnd[11];
    update.taken       = rnd[12];
    update.prediction  = rnd[14:13];
    rnd                = $urandom;
    update.target      = {rnd[15:1], 1'b0};         // Anywhere, forces tag misses later
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    drive_idle();
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    // Idle cycles first, then random traffic
    for (int n = 0; n < SEQ_CYCLES + RANDOM_CYCLES; n++) begin
      if (n < SEQ_CYCLES) begin
        drive_idle();
      end else begin
        drive_random();
      end
      #(2 * HALF_PERIOD - 2);  // 1 ns before the edge
      check_outputs();
      advance_model();
      @(posedge clk);
      #1;
    end
    $display("All tests passed");
    $finish;
  end

endmodule
